//--- logic/riscv_pkg.sv
package riscv_pkg;

  // ----------------------------------------------------------
  // Data width
  // ----------------------------------------------------------
  localparam int XLEN = 32;

  // funct7 values used by OP and by the OP-IMM shifts
  localparam logic [6:0] F7_BASE = 7'b000_0000;
  localparam logic [6:0] F7_ALT  = 7'b010_0000;

  // ----------------------------------------------------------
  // Major opcodes
  // ----------------------------------------------------------
  // Only integer computational forms, anything else is illegal
  typedef enum logic [6:0] {
    OP     = 7'b011_0011,
    OP_IMM = 7'b001_0011,
    LUI    = 7'b011_0111,
    AUIPC  = 7'b001_0111
  } opcode_e;

  // ----------------------------------------------------------
  // funct3 for OP and OP-IMM
  // ----------------------------------------------------------
  typedef enum logic [2:0] {
    ADD_SUB = 3'b000,
    SLL     = 3'b001,
    SLT     = 3'b010,
    SLTU    = 3'b011,
    XOR     = 3'b100,
    SRL_SRA = 3'b101,
    OR      = 3'b110,
    AND     = 3'b111
  } funct3_e;

endpackage

//--- logic/core_pkg.sv
package core_pkg;

  // ----------------------------------------------------------
  // Register file addressing
  // ----------------------------------------------------------
  localparam int REG_ADR_W = 5;

  // ----------------------------------------------------------
  // ALU operations
  // ----------------------------------------------------------
  // SUB is ALU_ADD with op2 negated in decode
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SLL  = 4'd1,
    ALU_SLT  = 4'd2,
    ALU_SLTU = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SRL  = 4'd5,
    ALU_SRA  = 4'd6,
    ALU_OR   = 4'd7,
    ALU_AND  = 4'd8
  } alu_op_e;

endpackage

//--- logic/decoder.sv
module decoder import riscv_pkg::*, core_pkg::*; (
  input  logic [XLEN-1:0]      instr_i,
  output logic                 illegal_o,
  output logic                 rd_v_o,
  output logic [REG_ADR_W-1:0] rd_o,
  output logic                 rs1_v_o,
  output logic [REG_ADR_W-1:0] rs1_adr_o,
  output logic                 rs2_v_o,
  output logic [REG_ADR_W-1:0] rs2_adr_o,
  output logic                 auipc_o,
  output logic                 rs2_is_imm_o,
  output logic [XLEN-1:0]      imm_o,
  output logic                 unsign_o,
  output alu_op_e              alu_op_o,
  output logic                 rs2_neg_o
);

  opcode_e         opcode;
  funct3_e         funct3;
  logic [6:0]      funct7;
  logic            f7_base;
  logic            f7_alt;
  logic [XLEN-1:0] imm_i_type;
  logic [XLEN-1:0] imm_u_type;
  logic            legal;
  logic            rd_v;
  logic            rs1_v;
  logic            rs2_v;

  // ----------------------------------------------------------
  // Field extraction
  // ----------------------------------------------------------
  assign opcode  = opcode_e'(instr_i[6:0]);
  assign funct3  = funct3_e'(instr_i[14:12]);
  assign funct7  = instr_i[31:25];
  assign f7_base = (funct7 == F7_BASE);
  assign f7_alt  = (funct7 == F7_ALT);

  assign rd_o      = instr_i[11:7];
  assign rs1_adr_o = instr_i[19:15];
  assign rs2_adr_o = instr_i[24:20];

  assign imm_i_type = {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};
  assign imm_u_type = {instr_i[31:12], 12'b0};

  // ----------------------------------------------------------
  // Instruction class and legality
  // ----------------------------------------------------------
  always_comb begin
    legal        = 1'b0;
    rd_v         = 1'b0;
    rs1_v        = 1'b0;
    rs2_v        = 1'b0;
    auipc_o      = 1'b0;
    rs2_is_imm_o = 1'b0;
    imm_o        = '0;
    case (opcode)
      OP: begin
        // Alternate funct7 only for SUB and SRA
        legal = f7_base | (f7_alt & ((funct3 == ADD_SUB) || (funct3 == SRL_SRA)));
        rd_v  = 1'b1;
        rs1_v = 1'b1;
        rs2_v = 1'b1;
      end
      OP_IMM: begin
        // Shift immediates keep funct7 in the upper bits
        if (funct3 == SLL) begin
          legal = f7_base;
        end else if (funct3 == SRL_SRA) begin
          legal = f7_base | f7_alt;
        end else begin
          legal = 1'b1;
        end
        rd_v         = 1'b1;
        rs1_v        = 1'b1;
        rs2_is_imm_o = 1'b1;
        imm_o        = imm_i_type;
      end
      LUI: begin
        legal        = 1'b1;
        rd_v         = 1'b1;
        rs2_is_imm_o = 1'b1;
        imm_o        = imm_u_type;
      end
      AUIPC: begin
        legal        = 1'b1;
        rd_v         = 1'b1;
        auipc_o      = 1'b1;
        rs2_is_imm_o = 1'b1;
        imm_o        = imm_u_type;
      end
      default: ;
    endcase
  end

  assign illegal_o = ~legal;
  assign rd_v_o    = rd_v & legal;
  assign rs1_v_o   = rs1_v & legal;
  assign rs2_v_o   = rs2_v & legal;

  // ----------------------------------------------------------
  // ALU operation select
  // ----------------------------------------------------------
  always_comb begin
    alu_op_o  = ALU_ADD;
    unsign_o  = 1'b0;
    rs2_neg_o = 1'b0;
    if ((opcode == OP) || (opcode == OP_IMM)) begin
      case (funct3)
        ADD_SUB: rs2_neg_o = (opcode == OP) & f7_alt;
        SLL:     alu_op_o  = ALU_SLL;
        SLT: begin
          alu_op_o  = ALU_SLT;
          rs2_neg_o = 1'b1;
        end
        SLTU: begin
          alu_op_o  = ALU_SLTU;
          rs2_neg_o = 1'b1;
          unsign_o  = 1'b1;
        end
        XOR:     alu_op_o = ALU_XOR;
        SRL_SRA: alu_op_o = f7_alt ? ALU_SRA : ALU_SRL;
        OR:      alu_op_o = ALU_OR;
        AND:     alu_op_o = ALU_AND;
        default: ;
      endcase
    end
  end

endmodule

//--- logic/dec.sv
module dec import riscv_pkg::*, core_pkg::*; (
  input  logic                 clk,
  input  logic                 reset_n,
  // Instruction feed
  input  logic                 instr_v_i,
  input  logic [XLEN-1:0]      instr_i,
  input  logic [XLEN-1:0]      pc_i,
  input  logic                 flush_i,
  // Register file read ports
  output logic [REG_ADR_W-1:0] rf_rs1_adr_o,
  input  logic [XLEN-1:0]      rf_rs1_data_i,
  output logic [REG_ADR_W-1:0] rf_rs2_adr_o,
  input  logic [XLEN-1:0]      rf_rs2_data_i,
  // Forward from execute
  input  logic                 exe_ff_v_i,
  input  logic [REG_ADR_W-1:0] exe_ff_rd_adr_i,
  input  logic [XLEN-1:0]      exe_ff_data_i,
  // Forward from write-back
  input  logic                 wb_ff_v_i,
  input  logic [REG_ADR_W-1:0] wb_ff_rd_adr_i,
  input  logic [XLEN-1:0]      wb_ff_data_i,
  // To execute
  output logic                 illegal_q_o,
  output logic                 instr_v_q_o,
  output logic                 rd_v_q_o,
  output logic [REG_ADR_W-1:0] rd_adr_q_o,
  output logic [XLEN:0]        op1_q_o,
  output logic [XLEN:0]        op2_q_o,
  output alu_op_e              alu_op_q_o
);

  logic                 illegal;
  logic                 rd_v;
  logic [REG_ADR_W-1:0] rd_adr;
  logic                 rs1_v;
  logic                 rs2_v;
  logic                 auipc;
  logic                 rs2_is_imm;
  logic [XLEN-1:0]      imm;
  logic                 unsign;
  alu_op_e              alu_op;
  logic                 rs2_neg;
  logic                 exe_rs1_hit;
  logic                 exe_rs2_hit;
  logic                 wb_rs1_hit;
  logic                 wb_rs2_hit;
  logic [XLEN-1:0]      rs1_fwd;
  logic [XLEN-1:0]      rs2_fwd;
  logic [XLEN-1:0]      op1;
  logic [XLEN-1:0]      op2;
  logic [XLEN:0]        op2_ext;
  logic                 instr_v;

  decoder u_decoder (
    .instr_i      (instr_i),
    .illegal_o    (illegal),
    .rd_v_o       (rd_v),
    .rd_o         (rd_adr),
    .rs1_v_o      (rs1_v),
    .rs1_adr_o    (rf_rs1_adr_o),
    .rs2_v_o      (rs2_v),
    .rs2_adr_o    (rf_rs2_adr_o),
    .auipc_o      (auipc),
    .rs2_is_imm_o (rs2_is_imm),
    .imm_o        (imm),
    .unsign_o     (unsign),
    .alu_op_o     (alu_op),
    .rs2_neg_o    (rs2_neg)
  );

  // ----------------------------------------------------------
  // Operand forwarding, execute before write-back before RF
  // ----------------------------------------------------------
  assign exe_rs1_hit = exe_ff_v_i & (exe_ff_rd_adr_i != '0) & (exe_ff_rd_adr_i == rf_rs1_adr_o);
  assign exe_rs2_hit = exe_ff_v_i & (exe_ff_rd_adr_i != '0) & (exe_ff_rd_adr_i == rf_rs2_adr_o);
  assign wb_rs1_hit  = wb_ff_v_i & (wb_ff_rd_adr_i != '0) & (wb_ff_rd_adr_i == rf_rs1_adr_o);
  assign wb_rs2_hit  = wb_ff_v_i & (wb_ff_rd_adr_i != '0) & (wb_ff_rd_adr_i == rf_rs2_adr_o);

  assign rs1_fwd = exe_rs1_hit ? exe_ff_data_i : wb_rs1_hit ? wb_ff_data_i : rf_rs1_data_i;
  assign rs2_fwd = exe_rs2_hit ? exe_ff_data_i : wb_rs2_hit ? wb_ff_data_i : rf_rs2_data_i;

  // ----------------------------------------------------------
  // Operand qualification
  // ----------------------------------------------------------
  // LUI has neither rs1 nor PC, so op1 falls to zero
  assign op1 = auipc ? pc_i : (rs1_v ? rs1_fwd : '0);
  assign op2 = rs2_is_imm ? imm : (rs2_v ? rs2_fwd : '0);

  assign op2_ext = {~unsign & op2[XLEN-1], op2};

  // Flush drops the instruction entering decode
  assign instr_v = instr_v_i & ~flush_i;

  always_ff @(posedge clk, negedge reset_n) begin
    if (!reset_n) begin
      illegal_q_o <= 1'b0;
      instr_v_q_o <= 1'b0;
      rd_v_q_o    <= 1'b0;
      rd_adr_q_o  <= '0;
      op1_q_o     <= '0;
      op2_q_o     <= '0;
      alu_op_q_o  <= ALU_ADD;
    end else begin
      illegal_q_o <= instr_v & illegal;
      instr_v_q_o <= instr_v;
      rd_v_q_o    <= instr_v & rd_v;
      rd_adr_q_o  <= rd_adr;
      op1_q_o     <= {~unsign & op1[XLEN-1], op1};
      // Two's complement for SUB and the compares
      op2_q_o     <= rs2_neg ? (~op2_ext + 1'b1) : op2_ext;
      alu_op_q_o  <= alu_op;
    end
  end

endmodule

//--- logic/reg_file.sv
module reg_file import riscv_pkg::*, core_pkg::*; (
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic [REG_ADR_W-1:0] rs1_adr_i,
  output logic [XLEN-1:0]      rs1_data_o,
  input  logic [REG_ADR_W-1:0] rs2_adr_i,
  output logic [XLEN-1:0]      rs2_data_o,
  input  logic                 wr_v_i,
  input  logic [REG_ADR_W-1:0] wr_adr_i,
  input  logic [XLEN-1:0]      wr_data_i
);

  // x1 to x31, x0 has no storage
  logic [XLEN-1:0] regs [1:2**REG_ADR_W-1];

  always_ff @(posedge clk, negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 1; i < 2**REG_ADR_W; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_v_i && (wr_adr_i != '0)) begin
      regs[wr_adr_i] <= wr_data_i;
    end
  end

  // Combinational reads
  assign rs1_data_o = (rs1_adr_i == '0) ? '0 : regs[rs1_adr_i];
  assign rs2_data_o = (rs2_adr_i == '0) ? '0 : regs[rs2_adr_i];

endmodule

//--- logic/exe.sv
module exe import riscv_pkg::*, core_pkg::*; (
  input  logic                 clk,
  input  logic                 reset_n,
  // From decode
  input  logic                 v_i,
  input  logic                 rd_v_i,
  input  logic [REG_ADR_W-1:0] rd_adr_i,
  input  logic [XLEN:0]        op1_i,
  input  logic [XLEN:0]        op2_i,
  input  alu_op_e              alu_op_i,
  // Forward of the current result
  output logic                 ff_v_o,
  output logic [REG_ADR_W-1:0] ff_rd_adr_o,
  output logic [XLEN-1:0]      ff_data_o,
  // Write-back register
  output logic                 wb_v_q_o,
  output logic [REG_ADR_W-1:0] wb_rd_adr_q_o,
  output logic [XLEN-1:0]      wb_data_q_o
);

  logic [XLEN:0]   sum;
  logic [4:0]      shamt;
  logic [XLEN:0]   sra_res;

  // ----------------------------------------------------------
  // ALU
  // ----------------------------------------------------------
  // op2 already negated for SUB, SLT and SLTU
  assign sum     = op1_i + op2_i;
  assign shamt   = op2_i[4:0];
  // op1 carries its sign in bit 32 for SRA
  assign sra_res = $signed(op1_i) >>> shamt;

  always_comb begin
    case (alu_op_i)
      ALU_ADD:  ff_data_o = sum[XLEN-1:0];
      ALU_SLL:  ff_data_o = op1_i[XLEN-1:0] << shamt;
      ALU_SLT,
      ALU_SLTU: ff_data_o = {{(XLEN-1){1'b0}}, sum[XLEN]};
      ALU_XOR:  ff_data_o = op1_i[XLEN-1:0] ^ op2_i[XLEN-1:0];
      ALU_SRL:  ff_data_o = op1_i[XLEN-1:0] >> shamt;
      ALU_SRA:  ff_data_o = sra_res[XLEN-1:0];
      ALU_OR:   ff_data_o = op1_i[XLEN-1:0] | op2_i[XLEN-1:0];
      ALU_AND:  ff_data_o = op1_i[XLEN-1:0] & op2_i[XLEN-1:0];
      default:  ff_data_o = '0;
    endcase
  end

  assign ff_v_o      = v_i & rd_v_i;
  assign ff_rd_adr_o = rd_adr_i;

  // ----------------------------------------------------------
  // Write-back register
  // ----------------------------------------------------------
  always_ff @(posedge clk, negedge reset_n) begin
    if (!reset_n) begin
      wb_v_q_o      <= 1'b0;
      wb_rd_adr_q_o <= '0;
      wb_data_q_o   <= '0;
    end else begin
      wb_v_q_o      <= ff_v_o;
      wb_rd_adr_q_o <= ff_rd_adr_o;
      wb_data_q_o   <= ff_data_o;
    end
  end

endmodule

//--- logic/core_top.sv
module core_top import riscv_pkg::*, core_pkg::*; (
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic                 instr_v_i,
  input  logic [XLEN-1:0]      instr_i,
  input  logic [XLEN-1:0]      pc_i,
  input  logic                 flush_i,
  output logic                 illegal_o,
  output logic                 wb_v_o,
  output logic [REG_ADR_W-1:0] wb_rd_o,
  output logic [XLEN-1:0]      wb_data_o
);

  logic [REG_ADR_W-1:0] rf_rs1_adr;
  logic [REG_ADR_W-1:0] rf_rs2_adr;
  logic [XLEN-1:0]      rf_rs1_data;
  logic [XLEN-1:0]      rf_rs2_data;
  logic                 ex_v;
  logic                 ex_rd_v;
  logic [REG_ADR_W-1:0] ex_rd_adr;
  logic [XLEN:0]        ex_op1;
  logic [XLEN:0]        ex_op2;
  alu_op_e              ex_op;
  logic                 exe_ff_v;
  logic [REG_ADR_W-1:0] exe_ff_rd_adr;
  logic [XLEN-1:0]      exe_ff_data;
  logic                 wb_v;
  logic [REG_ADR_W-1:0] wb_rd_adr;
  logic [XLEN-1:0]      wb_data;

  // ----------------------------------------------------------
  // Decode
  // ----------------------------------------------------------
  dec u_dec (
    .clk             (clk),
    .reset_n         (reset_n),
    .instr_v_i       (instr_v_i),
    .instr_i         (instr_i),
    .pc_i            (pc_i),
    .flush_i         (flush_i),
    .rf_rs1_adr_o    (rf_rs1_adr),
    .rf_rs1_data_i   (rf_rs1_data),
    .rf_rs2_adr_o    (rf_rs2_adr),
    .rf_rs2_data_i   (rf_rs2_data),
    .exe_ff_v_i      (exe_ff_v),
    .exe_ff_rd_adr_i (exe_ff_rd_adr),
    .exe_ff_data_i   (exe_ff_data),
    .wb_ff_v_i       (wb_v),
    .wb_ff_rd_adr_i  (wb_rd_adr),
    .wb_ff_data_i    (wb_data),
    .illegal_q_o     (illegal_o),
    .instr_v_q_o     (ex_v),
    .rd_v_q_o        (ex_rd_v),
    .rd_adr_q_o      (ex_rd_adr),
    .op1_q_o         (ex_op1),
    .op2_q_o         (ex_op2),
    .alu_op_q_o      (ex_op)
  );

  // Written from the write-back register
  reg_file u_reg_file (
    .clk        (clk),
    .reset_n    (reset_n),
    .rs1_adr_i  (rf_rs1_adr),
    .rs1_data_o (rf_rs1_data),
    .rs2_adr_i  (rf_rs2_adr),
    .rs2_data_o (rf_rs2_data),
    .wr_v_i     (wb_v),
    .wr_adr_i   (wb_rd_adr),
    .wr_data_i  (wb_data)
  );

  // ----------------------------------------------------------
  // Execute
  // ----------------------------------------------------------
  exe u_exe (
    .clk           (clk),
    .reset_n       (reset_n),
    .v_i           (ex_v),
    .rd_v_i        (ex_rd_v),
    .rd_adr_i      (ex_rd_adr),
    .op1_i         (ex_op1),
    .op2_i         (ex_op2),
    .alu_op_i      (ex_op),
    .ff_v_o        (exe_ff_v),
    .ff_rd_adr_o   (exe_ff_rd_adr),
    .ff_data_o     (exe_ff_data),
    .wb_v_q_o      (wb_v),
    .wb_rd_adr_q_o (wb_rd_adr),
    .wb_data_q_o   (wb_data)
  );

  assign wb_v_o    = wb_v;
  assign wb_rd_o   = wb_rd_adr;
  assign wb_data_o = wb_data;

endmodule

//--- tb/core_top_tb.sv
module core_top_tb import riscv_pkg::*, core_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ns;

  logic                 clk;
  logic                 reset_n;
  logic                 instr_v_i;
  logic [XLEN-1:0]      instr_i;
  logic [XLEN-1:0]      pc_i;
  logic                 flush_i;
  logic                 illegal_o;
  logic                 wb_v_o;
  logic [REG_ADR_W-1:0] wb_rd_o;
  logic [XLEN-1:0]      wb_data_o;

  // Stimulus lines as read from the file
  string                name_l[$];
  bit                   flush_l[$];
  logic [XLEN-1:0]      instr_l[$];
  bit                   ill_l[$];
  logic [REG_ADR_W-1:0] rd_l[$];
  logic [XLEN-1:0]      res_l[$];

  // Scoreboard
  string                wb_name_q[$];
  logic [REG_ADR_W-1:0] wb_rd_q[$];
  logic [XLEN-1:0]      wb_data_q[$];
  int                   wb_due_q[$];
  string                cur_name;
  bit                   cur_exp_ill;
  string                ill_name_q;
  bit                   exp_ill_q;
  int                   errors;
  int                   cycles;
  int                   cycle_limit;

  core_top dut (
    .clk       (clk),
    .reset_n   (reset_n),
    .instr_v_i (instr_v_i),
    .instr_i   (instr_i),
    .pc_i      (pc_i),
    .flush_i   (flush_i),
    .illegal_o (illegal_o),
    .wb_v_o    (wb_v_o),
    .wb_rd_o   (wb_rd_o),
    .wb_data_o (wb_data_o)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // ------------------------------------------------------------
  // Compare tasks
  // ------------------------------------------------------------
  task automatic check_wb(input string name, input logic [REG_ADR_W-1:0] exp_rd,
                          input logic [XLEN-1:0] exp_data);
    if (wb_rd_o !== exp_rd) begin
      errors++;
      $display("Fail %s: wb rd expected x%0d actual x%0d", name, exp_rd, wb_rd_o);
    end
    if (wb_data_o !== exp_data) begin
      errors++;
      $display("Fail %s: wb data expected %h actual %h", name, exp_data, wb_data_o);
    end
  endtask

  task automatic check_wb_cycle(input string name, input int exp_cycle);
    if (cycles != exp_cycle) begin
      errors++;
      $display("Fail %s: wb cycle expected %0d actual %0d", name, exp_cycle, cycles);
    end
  endtask

  task automatic check_illegal(input string name, input bit exp_ill);
    if (illegal_o !== exp_ill) begin
      errors++;
      $display("Fail %s: illegal expected %b actual %b", name, exp_ill, illegal_o);
    end
  endtask

  // Drive one stimulus line and queue its expected write-back
  task automatic apply_instr(input int idx);
    instr_v_i   = (name_l[idx] != "gap");
    flush_i     = flush_l[idx];
    instr_i     = instr_l[idx];
    pc_i        = 32'h0000_0100 + 4 * idx;
    cur_name    = name_l[idx];
    cur_exp_ill = ill_l[idx];
    if (instr_v_i && !flush_l[idx] && !ill_l[idx]) begin
      wb_name_q.push_back(name_l[idx]);
      wb_rd_q.push_back(rd_l[idx]);
      wb_data_q.push_back(res_l[idx]);
      // Sampled at the next edge, written back one edge after that
      wb_due_q.push_back(cycles + 2);
    end
  endtask

  // ------------------------------------------------------------
  // Monitor
  // ------------------------------------------------------------
  // Expected illegal flag follows the instruction sampled at the edge
  always @(posedge clk) begin
    exp_ill_q  <= cur_exp_ill;
    ill_name_q <= cur_name;
  end

  always @(negedge clk) begin
    check_illegal(ill_name_q, exp_ill_q);
    if (wb_v_o) begin
      if (wb_rd_q.size() == 0) begin
        errors++;
        $display("Error: write-back to x%0d appeared with no instruction pending", wb_rd_o);
      end else begin
        check_wb_cycle(wb_name_q[0], wb_due_q.pop_front());
        check_wb(wb_name_q.pop_front(), wb_rd_q.pop_front(), wb_data_q.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      $display("Error: run did not finish within %0d cycles", cycle_limit);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin
    int    fd;
    int    n;
    int    rd_tmp;
    string text;
    string name;
    bit    fl;
    bit    ill;
    logic [XLEN-1:0] word;
    logic [XLEN-1:0] res;
    reset_n     = 1'b0;
    instr_v_i   = 1'b0;
    instr_i     = '0;
    pc_i        = '0;
    flush_i     = 1'b0;
    cur_name    = "reset";
    cur_exp_ill = 1'b0;
    ill_name_q  = "reset";
    exp_ill_q   = 1'b0;
    errors      = 0;
    cycles      = 0;
    cycle_limit = 0;

    fd = $fopen("tb/core_stim.txt", "r");
    if (fd == 0) begin
      $display("Error: stimulus file tb/core_stim.txt could not be opened");
      $display("SIMULATION FAILED");
      $finish;
    end else begin
      while ($fgets(text, fd)) begin
        if (text.len() < 2 || text.substr(0, 0) == "#") continue;
        n = $sscanf(text, "%s %b %h %b %d %h", name, fl, word, ill, rd_tmp, res);
        if (n != 6) continue;
        name_l.push_back(name);
        flush_l.push_back(fl);
        instr_l.push_back(word);
        ill_l.push_back(ill);
        rd_l.push_back(rd_tmp[REG_ADR_W-1:0]);
        res_l.push_back(res);
      end
      $fclose(fd);
      cycle_limit = name_l.size() + 4 + 10;

      repeat (4) @(posedge clk);
      #5 reset_n = 1'b1;

      for (int i = 0; i < name_l.size(); i++) begin
        @(posedge clk);
        #5 apply_instr(i);
      end
      @(posedge clk);
      #5;
      instr_v_i   = 1'b0;
      flush_i     = 1'b0;
      cur_name    = "idle";
      cur_exp_ill = 1'b0;

      // Drain, then a few idle cycles to catch stray write-backs
      while (wb_rd_q.size() != 0) @(posedge clk);
      repeat (3) @(negedge clk);

      $display("Errors: %0d", errors);
      if (errors == 0) begin
        $display("SIMULATION PASSED");
      end else begin
        $display("SIMULATION FAILED");
      end
      $finish;
    end
  end

endmodule

//--- tb/core_stim.txt
# name flush instr(hex) illegal rd(dec) result(hex); pc is 0x100 plus 4 per line
# name gap holds instr_v low
addi_x1      0 00500093 0 1  00000005
addi_x2_neg  0 FFD00113 0 2  FFFFFFFD
xori_wbfwd   0 0F00C193 0 3  000000F5
slti_neg     0 FFE12213 0 4  00000001
sltiu_big    0 00713293 0 5  00000000
slli         0 00409313 0 6  00000050
srli         0 01C15393 0 7  0000000F
srai         0 40115413 0 8  FFFFFFFE
lui          0 123454B7 0 9  12345000
auipc        0 00001517 0 10 00001124
add          0 002085B3 0 11 00000002
sub          0 40208633 0 12 00000008
slt_neg      0 001126B3 0 13 00000001
sltu_big     0 00113733 0 14 00000000
sltu_small   0 0020B7B3 0 15 00000001
xor          0 00744833 0 16 FFFFFFF1
sll          0 007098B3 0 17 00028000
sra          0 40145933 0 18 FFFFFFFF
srl          0 001459B3 0 19 07FFFFFF
or           0 0091EA33 0 20 123450F5
and          0 00A4FAB3 0 21 00001000
addi_x22     0 06400B13 0 22 00000064
addi_exefwd  0 001B0B13 0 22 00000065
add_newest   0 016B0BB3 0 23 000000CA
addi_x0      0 00700013 0 0  00000007
add_x0_d1    0 00100C33 0 24 00000005
sub_x0_d2    0 40100CB3 0 25 FFFFFFFB
lw_illegal   0 0000AD03 1 0  00000000
beq_illegal  0 00208463 1 0  00000000
mul_funct7   0 02208DB3 1 0  00000000
gap          0 00000000 0 0  00000000
addi_flushed 1 00900E13 0 0  00000000
lw_flushed   1 0000AD03 0 0  00000000
addi_x28_rd  0 000E0E93 0 29 00000000
add_rf       0 004B8F33 0 30 000000CB

//--- core_top.f
logic/riscv_pkg.sv
logic/core_pkg.sv
logic/decoder.sv
logic/dec.sv
logic/reg_file.sv
logic/exe.sv
logic/core_top.sv
tb/core_top_tb.sv

//--- Bender.yml
package:
  name: core_top

sources:
  - logic/riscv_pkg.sv
  - logic/core_pkg.sv
  - logic/decoder.sv
  - logic/dec.sv
  - logic/reg_file.sv
  - logic/exe.sv
  - logic/core_top.sv
  - target: test
    files:
      - tb/core_top_tb.sv
